//--- cpuCore.f
+incdir+rtl
rtl/cpuTypes.sv
rtl/registerFile.sv
rtl/cpuAlu.sv
rtl/cpuControl.sv
rtl/cpuDatapath.sv
rtl/cpuCore.sv
sim/cpuCoreTb.sv

//--- rtl/cpuAlu.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuAlu (
    input  cpuTypes::aluOpT         op,
    input  logic [`DATA_WIDTH-1:0]  a,
    input  logic [`DATA_WIDTH-1:0]  b,
    output logic [`DATA_WIDTH-1:0]  result,
    output logic                    zero,
    output logic                    positive
);
    import cpuTypes::*;

    localparam int halfWidth = `DATA_WIDTH / 2;

    always_comb
    begin
        case (op)
            aluSub:
            begin
                result = a - b;
            end
            aluLoadHigh:
            begin
                result = {b[halfWidth-1:0], {halfWidth{1'b0}}};
            end
            aluLoadLow:
            begin
                // keep the upper half of a
                result = {a[`DATA_WIDTH-1:halfWidth], b[halfWidth-1:0]};
            end
            default:
            begin
                result = a + b;
            end
        endcase
    end

    assign zero     = (result == '0);
    assign positive = !zero && !result[`DATA_WIDTH-1];

endmodule

//--- rtl/cpuControl.sv
`timescale 1ns/1ns

module cpuControl (
    input  logic              CLK,
    input  logic              Reset,
    input  cpuTypes::opcodeT  opcode,
    input  logic              aluZero,
    input  logic              wbAck,
    output logic              wbCyc,
    output logic              wbStb,
    output logic              wbWe,
    output logic              pcWrite,
    output logic              irWrite,
    output logic              mdrWrite,
    output logic              regWrite,
    output logic              aluOutWrite,
    output logic              useAluOutAddr,
    output cpuTypes::aluOpT   aluOp,
    output cpuTypes::srcAT    srcA,
    output cpuTypes::srcBT    srcB,
    output cpuTypes::regSrcT  regSrc,
    output cpuTypes::pcSrcT   pcSrc
);
    import cpuTypes::*;

    stateT state;
    stateT nextState;
    logic  busActive;
    logic  busDone;

    function automatic logic isAccess(input stateT s);
        return (s == stFetch) || (s == stLoadRead) || (s == stStore);
    endfunction

    assign busDone = busActive && wbAck;

    assign wbCyc = busActive;
    assign wbStb = busActive;
    assign wbWe  = busActive && (state == stStore);

    always_ff @(posedge CLK or posedge Reset)
    begin
        if (Reset)
        begin
            state     <= stFetch;
            busActive <= 1'b0;
        end
        else
        begin
            state <= nextState;
            // drop the cycle after ack, so a store never runs into the next fetch
            busActive <= isAccess(nextState) && !busDone;
        end
    end

    always_comb
    begin
        nextState     = state;
        pcWrite       = 1'b0;
        irWrite       = 1'b0;
        mdrWrite      = 1'b0;
        regWrite      = 1'b0;
        aluOutWrite   = 1'b0;
        useAluOutAddr = 1'b0;
        aluOp         = aluAdd;
        srcA          = srcAPc;
        srcB          = srcBOne;
        regSrc        = regFromAlu;
        pcSrc         = pcFromAlu;

        case (state)
            stFetch:
            begin
                // PC + 1 also lands in ALUOut as the link value
                if (busDone)
                begin
                    irWrite     = 1'b1;
                    pcWrite     = 1'b1;
                    aluOutWrite = 1'b1;
                    nextState   = stDecode;
                end
            end
            stDecode:
            begin
                // bne target precomputed here
                srcB        = srcBImm;
                aluOutWrite = (opcode == opBne);
                case (opcode)
                    opAdd, opSub: nextState = stExecAdd;
                    opSgt, opSeq: nextState = stExecCompare;
                    opJal: nextState = stExecJal;
                    opJalr: nextState = stExecJalr;
                    opAddi, opLw, opSw: nextState = stMemAddr;
                    opBne: nextState = stBranch;
                    opLui, opLli: nextState = stImmCalc;
                    default: nextState = stFetch;
                endcase
            end
            stExecAdd:
            begin
                srcA        = srcARegA;
                srcB        = srcBRegB;
                aluOp       = (opcode == opSub) ? aluSub : aluAdd;
                aluOutWrite = 1'b1;
                nextState   = stWriteAlu;
            end
            stExecCompare:
            begin
                srcA        = srcARegA;
                srcB        = srcBRegB;
                aluOp       = aluSub;
                aluOutWrite = 1'b1;
                nextState   = (opcode == opSgt) ? stWriteGreater : stWriteEqual;
            end
            stWriteAlu, stAddiWrite, stImmWrite, stWriteLink:
            begin
                regWrite  = 1'b1;
                nextState = stFetch;
            end
            stWriteGreater:
            begin
                regWrite  = 1'b1;
                regSrc    = regFromGreater;
                nextState = stFetch;
            end
            stWriteEqual:
            begin
                regWrite  = 1'b1;
                regSrc    = regFromEqual;
                nextState = stFetch;
            end
            stExecJal:
            begin
                srcB      = srcBImm;
                pcWrite   = 1'b1;
                nextState = stWriteLink;
            end
            stExecJalr:
            begin
                // immediate is zero for jalr, so the ALU passes rs through
                srcA      = srcARegA;
                srcB      = srcBImm;
                pcWrite   = 1'b1;
                nextState = stWriteLink;
            end
            stMemAddr:
            begin
                srcA        = srcARegA;
                srcB        = srcBImm;
                aluOutWrite = 1'b1;
                case (opcode)
                    opLw: nextState = stLoadRead;
                    opSw: nextState = stStore;
                    default: nextState = stAddiWrite;
                endcase
            end
            stLoadRead:
            begin
                useAluOutAddr = 1'b1;
                if (busDone)
                begin
                    mdrWrite  = 1'b1;
                    nextState = stLoadWrite;
                end
            end
            stLoadWrite:
            begin
                regWrite  = 1'b1;
                regSrc    = regFromMem;
                nextState = stFetch;
            end
            stStore:
            begin
                useAluOutAddr = 1'b1;
                if (busDone)
                begin
                    nextState = stFetch;
                end
            end
            stBranch:
            begin
                // B holds rd here, taken when rs differs
                srcA      = srcARegA;
                srcB      = srcBRegB;
                aluOp     = aluSub;
                pcSrc     = pcFromAluOut;
                pcWrite   = !aluZero;
                nextState = stFetch;
            end
            stImmCalc:
            begin
                srcA        = srcARegD;
                srcB        = srcBImm;
                aluOp       = (opcode == opLui) ? aluLoadHigh : aluLoadLow;
                aluOutWrite = 1'b1;
                nextState   = stImmWrite;
            end
            default:
            begin
                nextState = stFetch;
            end
        endcase
    end

endmodule

//--- rtl/cpuCore.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuCore (
    input  logic                    CLK,
    input  logic                    Reset,
    output logic                    wbCyc,
    output logic                    wbStb,
    output logic                    wbWe,
    output logic [`DATA_WIDTH-1:0]  wbAdr,
    output logic [`DATA_WIDTH-1:0]  wbDatOut,
    input  logic [`DATA_WIDTH-1:0]  wbDatIn,
    input  logic                    wbAck
);
    import cpuTypes::*;

    logic    pcWrite;
    logic    irWrite;
    logic    mdrWrite;
    logic    regWrite;
    logic    aluOutWrite;
    logic    useAluOutAddr;
    aluOpT   aluOp;
    srcAT    srcA;
    srcBT    srcB;
    regSrcT  regSrc;
    pcSrcT   pcSrc;
    opcodeT  opcode;
    logic    aluZero;

    cpuControl cpuControl_i (
        .CLK           (CLK),
        .Reset         (Reset),
        .opcode        (opcode),
        .aluZero       (aluZero),
        .wbAck         (wbAck),
        .wbCyc         (wbCyc),
        .wbStb         (wbStb),
        .wbWe          (wbWe),
        .pcWrite       (pcWrite),
        .irWrite       (irWrite),
        .mdrWrite      (mdrWrite),
        .regWrite      (regWrite),
        .aluOutWrite   (aluOutWrite),
        .useAluOutAddr (useAluOutAddr),
        .aluOp         (aluOp),
        .srcA          (srcA),
        .srcB          (srcB),
        .regSrc        (regSrc),
        .pcSrc         (pcSrc)
    );

    cpuDatapath cpuDatapath_i (
        .CLK           (CLK),
        .Reset         (Reset),
        .pcWrite       (pcWrite),
        .irWrite       (irWrite),
        .mdrWrite      (mdrWrite),
        .regWrite      (regWrite),
        .aluOutWrite   (aluOutWrite),
        .useAluOutAddr (useAluOutAddr),
        .aluOp         (aluOp),
        .srcA          (srcA),
        .srcB          (srcB),
        .regSrc        (regSrc),
        .pcSrc         (pcSrc),
        .wbDatIn       (wbDatIn),
        .wbAdr         (wbAdr),
        .wbDatOut      (wbDatOut),
        .opcode        (opcode),
        .aluZero       (aluZero)
    );

endmodule

//--- rtl/cpuDatapath.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuDatapath (
    input  logic                    CLK,
    input  logic                    Reset,
    input  logic                    pcWrite,
    input  logic                    irWrite,
    input  logic                    mdrWrite,
    input  logic                    regWrite,
    input  logic                    aluOutWrite,
    input  logic                    useAluOutAddr,
    input  cpuTypes::aluOpT         aluOp,
    input  cpuTypes::srcAT          srcA,
    input  cpuTypes::srcBT          srcB,
    input  cpuTypes::regSrcT        regSrc,
    input  cpuTypes::pcSrcT         pcSrc,
    input  logic [`DATA_WIDTH-1:0]  wbDatIn,
    output logic [`DATA_WIDTH-1:0]  wbAdr,
    output logic [`DATA_WIDTH-1:0]  wbDatOut,
    output cpuTypes::opcodeT        opcode,
    output logic                    aluZero
);
    import cpuTypes::*;

    localparam int regAddrWidth = $clog2(`REG_COUNT);

    logic [`DATA_WIDTH-1:0]  pc;
    logic [`DATA_WIDTH-1:0]  ir;
    logic [`DATA_WIDTH-1:0]  mdr;
    logic [`DATA_WIDTH-1:0]  regA;
    logic [`DATA_WIDTH-1:0]  regB;
    logic [`DATA_WIDTH-1:0]  regD;
    logic [`DATA_WIDTH-1:0]  aluOut;
    logic                    equalFlag;
    logic                    greaterFlag;
    logic [regAddrWidth-1:0] rdField;
    logic [regAddrWidth-1:0] rsField;
    logic [regAddrWidth-1:0] rtField;
    logic [regAddrWidth-1:0] addrB;
    logic [`DATA_WIDTH-1:0]  readA;
    logic [`DATA_WIDTH-1:0]  readB;
    logic [`DATA_WIDTH-1:0]  readD;
    logic [`DATA_WIDTH-1:0]  immediate;
    logic [`DATA_WIDTH-1:0]  aluA;
    logic [`DATA_WIDTH-1:0]  aluB;
    logic [`DATA_WIDTH-1:0]  aluResult;
    logic                    aluPositive;
    logic [`DATA_WIDTH-1:0]  writeBack;

    assign opcode  = opcodeT'(ir[3:0]);
    assign rdField = ir[15:12];
    assign rsField = ir[11:8];
    assign rtField = ir[7:4];

    // bne compares rs against rd on the B port
    assign addrB = (opcode == opBne) ? rdField : rtField;

    always_comb
    begin
        case (opcode)
            opJal: immediate = {{(`DATA_WIDTH-8){ir[11]}}, ir[11:4]};
            opLui, opLli: immediate = {{(`DATA_WIDTH-8){1'b0}}, ir[11:4]};
            opJalr: immediate = '0;
            default: immediate = {{(`DATA_WIDTH-4){ir[7]}}, ir[7:4]};
        endcase
    end

    always_comb
    begin
        case (srcA)
            srcARegA: aluA = regA;
            srcARegD: aluA = regD;
            default: aluA = pc;
        endcase
        case (srcB)
            srcBRegB: aluB = regB;
            srcBImm: aluB = immediate;
            default: aluB = `DATA_WIDTH'(1);
        endcase
    end

    always_comb
    begin
        case (regSrc)
            regFromMem: writeBack = mdr;
            regFromEqual: writeBack = `DATA_WIDTH'(equalFlag);
            regFromGreater: writeBack = `DATA_WIDTH'(greaterFlag);
            default: writeBack = aluOut;
        endcase
    end

    always_ff @(posedge CLK or posedge Reset)
    begin
        if (Reset)
        begin
            pc          <= `RESET_PC;
            ir          <= '0;
            mdr         <= '0;
            regA        <= '0;
            regB        <= '0;
            regD        <= '0;
            aluOut      <= '0;
            equalFlag   <= 1'b0;
            greaterFlag <= 1'b0;
        end
        else
        begin
            // operand registers follow the register file every cycle
            regA <= readA;
            regB <= readB;
            regD <= readD;
            if (pcWrite)
            begin
                pc <= (pcSrc == pcFromAluOut) ? aluOut : aluResult;
            end
            if (irWrite)
            begin
                ir <= wbDatIn;
            end
            if (mdrWrite)
            begin
                mdr <= wbDatIn;
            end
            if (aluOutWrite)
            begin
                aluOut      <= aluResult;
                equalFlag   <= aluZero;
                greaterFlag <= aluPositive;
            end
        end
    end

    assign wbAdr    = useAluOutAddr ? aluOut : pc;
    assign wbDatOut = regD;

    registerFile registerFile_i (
        .CLK         (CLK),
        .Reset       (Reset),
        .readAddrA   (rsField),
        .readAddrB   (addrB),
        .readAddrD   (rdField),
        .writeAddr   (rdField),
        .writeEnable (regWrite),
        .writeData   (writeBack),
        .readDataA   (readA),
        .readDataB   (readB),
        .readDataD   (readD)
    );

    cpuAlu cpuAlu_i (
        .op       (aluOp),
        .a        (aluA),
        .b        (aluB),
        .result   (aluResult),
        .zero     (aluZero),
        .positive (aluPositive)
    );

endmodule

//--- rtl/cpuTypes.sv
package cpuTypes;

    // low nibble of the instruction word
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSgt  = 4'd1,
        opSub  = 4'd2,
        opSeq  = 4'd3,
        opJalr = 4'd4,
        opLui  = 4'd5,
        opJal  = 4'd6,
        opAddi = 4'd8,
        opLw   = 4'd9,
        opSw   = 4'd10,
        opBne  = 4'd11,
        opLli  = 4'd15
    } opcodeT;

    // control FSM states
    typedef enum logic [4:0] {
        stFetch,
        stDecode,
        stExecAdd,
        stExecCompare,
        stWriteAlu,
        stWriteGreater,
        stWriteEqual,
        stExecJal,
        stExecJalr,
        stWriteLink,
        stMemAddr,
        stLoadRead,
        stLoadWrite,
        stAddiWrite,
        stStore,
        stBranch,
        stImmCalc,
        stImmWrite
    } stateT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluLoadHigh,
        aluLoadLow
    } aluOpT;

    // ALU operand selects
    typedef enum logic [1:0] {srcAPc, srcARegA, srcARegD} srcAT;
    typedef enum logic [1:0] {srcBRegB, srcBOne, srcBImm} srcBT;

    // register write-back source
    typedef enum logic [1:0] {
        regFromAlu,
        regFromMem,
        regFromEqual,
        regFromGreater
    } regSrcT;

    // pcFromAluOut takes the precomputed branch target
    typedef enum logic {pcFromAlu, pcFromAluOut} pcSrcT;

endpackage

//--- rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data word, address and instruction width
`define DATA_WIDTH 16

// general purpose registers, register 0 reads as zero
`define REG_COUNT 16

// first fetch address after reset
`define RESET_PC 16'h0000

`endif

//--- rtl/registerFile.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module registerFile (
    input  logic                          CLK,
    input  logic                          Reset,
    input  logic [$clog2(`REG_COUNT)-1:0] readAddrA,
    input  logic [$clog2(`REG_COUNT)-1:0] readAddrB,
    input  logic [$clog2(`REG_COUNT)-1:0] readAddrD,
    input  logic [$clog2(`REG_COUNT)-1:0] writeAddr,
    input  logic                          writeEnable,
    input  logic [`DATA_WIDTH-1:0]        writeData,
    output logic [`DATA_WIDTH-1:0]        readDataA,
    output logic [`DATA_WIDTH-1:0]        readDataB,
    output logic [`DATA_WIDTH-1:0]        readDataD
);
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge CLK or posedge Reset)
    begin
        if (Reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable)
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // register 0 is hardwired
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
    assign readDataD = (readAddrD == '0) ? '0 : regs[readAddrD];

endmodule

//--- sim/cpuCoreTb.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuCoreTb;
    import cpuTypes::*;

    localparam int halfPeriod         = 20;
    localparam int resetCycles        = 8;
    localparam int patternWords       = 512;
    localparam int firstAccessTimeout = 20;
    localparam int runTimeout         = 5000;
    localparam int haltRepeats        = 4;

    logic                   CLK;
    logic                   Reset;
    logic                   wbCyc;
    logic                   wbStb;
    logic                   wbWe;
    logic [`DATA_WIDTH-1:0] wbAdr;
    logic [`DATA_WIDTH-1:0] wbDatOut;
    logic [`DATA_WIDTH-1:0] wbDatIn;
    logic                   wbAck;

    logic [`DATA_WIDTH-1:0] mem [0:(1 << `DATA_WIDTH)-1];
    logic [`DATA_WIDTH-1:0] patterns [0:patternWords-1];
    logic [`DATA_WIDTH-1:0] expectedAddr [$];
    logic [`DATA_WIDTH-1:0] expectedData [$];

    logic [7:0]             lfsrState;
    logic                   pending;
    int                     waitLeft;
    logic [`DATA_WIDTH-1:0] holdAdr;
    logic [`DATA_WIDTH-1:0] holdDat;
    logic                   holdWe;
    logic                   expectFetch;
    logic                   dataWrite;
    logic [`DATA_WIDTH-1:0] lastFetch;
    int                     sameFetches;
    int                     accessCount;
    int                     storeCount;
    int                     illegalCount;

    cpuCore cpuCore_i (
        .CLK      (CLK),
        .Reset    (Reset),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatOut (wbDatOut),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #halfPeriod CLK = ~CLK;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic compareWord(input string name, input logic [`DATA_WIDTH-1:0] actual,
                               input logic [`DATA_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            abortRun($sformatf("[FAIL] %0t ns %s: got %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic compareAddress(input string name, input logic [`DATA_WIDTH-1:0] actual,
                                  input logic [`DATA_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            abortRun($sformatf("[FAIL] %0t ns %s: got address %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic compareBit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            abortRun($sformatf("[FAIL] %0t ns %s: got %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    // 8-bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsrStep(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // two bits give 0 to 3 wait cycles
    task automatic drawDelay(output int delay);
        delay = 0;
        for (int b = 0; b < 2; b++)
        begin
            lfsrState = lfsrStep(lfsrState);
            delay = (delay << 1) | lfsrState[0];
        end
    endtask

    function automatic logic isKnownOpcode(input opcodeT op);
        case (op)
            opAdd, opSgt, opSub, opSeq, opJalr, opLui, opJal, opAddi, opLw, opSw, opBne, opLli:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    task automatic loadPatterns();
        int i;
        for (i = 0; i < patternWords; i++)
        begin
            patterns[i] = '0;
        end
        // unloaded words depend on the full address
        for (i = 0; i < (1 << `DATA_WIDTH); i++)
        begin
            mem[i] = `DATA_WIDTH'(i) ^ 16'hA5C3;
        end
        $readmemh("sim/cpuPatterns.txt", patterns);
        i = 0;
        while ((i + 2 < patternWords) && (patterns[i] == 16'd1 || patterns[i] == 16'd2))
        begin
            if (patterns[i] == 16'd1)
            begin
                mem[patterns[i+1]] = patterns[i+2];
            end
            else
            begin
                expectedAddr.push_back(patterns[i+1]);
                expectedData.push_back(patterns[i+2]);
            end
            i = i + 3;
        end
        if (expectedAddr.size() == 0)
        begin
            abortRun("the pattern file holds no expected stores");
        end
    endtask

    task automatic recordStore(input logic [`DATA_WIDTH-1:0] adr,
                               input logic [`DATA_WIDTH-1:0] dat);
        if (storeCount >= expectedAddr.size())
        begin
            abortRun($sformatf("unexpected extra write of %h to address %h", dat, adr));
        end
        else
        begin
            compareAddress($sformatf("wbAdr of store %0d", storeCount), adr,
                           expectedAddr[storeCount]);
            compareWord($sformatf("wbDatOut of store %0d", storeCount), dat,
                        expectedData[storeCount]);
            storeCount = storeCount + 1;
        end
        mem[adr] = dat;
    endtask

    task automatic startAccess();
        pending = 1'b1;
        holdAdr = wbAdr;
        holdDat = wbDatOut;
        holdWe  = wbWe;
        if (accessCount == 0)
        begin
            // reset vector
            compareAddress("wbAdr", wbAdr, `RESET_PC);
        end
        // fetches read, data accesses follow the fetched lw or sw
        compareBit("wbWe", wbWe, expectFetch ? 1'b0 : dataWrite);
        accessCount = accessCount + 1;
        drawDelay(waitLeft);
    endtask

    task automatic finishAccess();
        opcodeT fetched;
        pending = 1'b0;
        wbAck <= 1'b1;
        if (holdWe)
        begin
            recordStore(holdAdr, holdDat);
        end
        else
        begin
            wbDatIn <= mem[holdAdr];
        end
        if (expectFetch)
        begin
            fetched = opcodeT'(mem[holdAdr][3:0]);
            expectFetch = !(fetched == opLw || fetched == opSw);
            dataWrite = (fetched == opSw);
            if (!isKnownOpcode(fetched))
            begin
                illegalCount = illegalCount + 1;
            end
            sameFetches = (holdAdr == lastFetch) ? sameFetches + 1 : 0;
            lastFetch = holdAdr;
        end
        else
        begin
            expectFetch = 1'b1;
        end
    endtask

    // Wishbone slave memory
    always @(posedge CLK)
    begin
        if (Reset)
        begin
            pending = 1'b0;
        end
        else if (wbAck)
        begin
            wbAck <= 1'b0;
        end
        else if (wbStb)
        begin
            if (!pending)
            begin
                startAccess();
            end
            else
            begin
                compareAddress("wbAdr", wbAdr, holdAdr);
                compareBit("wbWe", wbWe, holdWe);
                if (holdWe)
                begin
                    compareWord("wbDatOut", wbDatOut, holdDat);
                end
            end
            compareBit("wbCyc", wbCyc, 1'b1);
            if (waitLeft == 0)
            begin
                finishAccess();
            end
            else
            begin
                waitLeft = waitLeft - 1;
            end
        end
        else if (pending)
        begin
            abortRun("wbStb fell before the access was acknowledged");
        end
    end

    initial
    begin
        int waitCycles;
        Reset        = 1'b1;
        wbAck        = 1'b0;
        wbDatIn      = '0;
        lfsrState    = 8'd58;
        pending      = 1'b0;
        waitLeft     = 0;
        expectFetch  = 1'b1;
        dataWrite    = 1'b0;
        lastFetch    = '0;
        sameFetches  = 0;
        accessCount  = 0;
        storeCount   = 0;
        illegalCount = 0;
        loadPatterns();

        for (int i = 0; i < resetCycles; i++)
        begin
            @(negedge CLK);
            compareBit("wbCyc", wbCyc, 1'b0);
            compareBit("wbStb", wbStb, 1'b0);
        end
        @(posedge CLK);
        Reset <= 1'b0;

        waitCycles = 0;
        while (accessCount == 0)
        begin
            @(negedge CLK);
            waitCycles = waitCycles + 1;
            if (waitCycles > firstAccessTimeout)
            begin
                abortRun("the core started no bus access after reset");
            end
        end

        // the final jal keeps fetching its own address
        waitCycles = 0;
        while (sameFetches < haltRepeats)
        begin
            @(negedge CLK);
            waitCycles = waitCycles + 1;
            if (waitCycles > runTimeout)
            begin
                abortRun("the program never reached its final jump");
            end
        end

        if (illegalCount == 0)
        begin
            abortRun("no illegal opcode was fetched by the program");
        end
        else if (storeCount != expectedAddr.size())
        begin
            abortRun($sformatf("only %0d of %0d expected stores were written",
                               storeCount, expectedAddr.size()));
        end
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- sim/cpuPatterns.txt
// kind address value: kind 1 loads a memory word, kind 2 is an expected store
// expected stores are listed in program order, asm operands are rd, rs, rt or imm
1 0000 140F  // lli  r1, 0x40      store base
1 0001 280F  // lli  r2, 0x80      data base
1 0002 3209  // lw   r3, 0(r2)
1 0003 4219  // lw   r4, 1(r2)
1 0004 5340  // add  r5, r3, r4
1 0005 510A  // sw   r5, 0(r1)
1 0006 6342  // sub  r6, r3, r4
1 0007 611A  // sw   r6, 1(r1)
1 0008 7341  // sgt  r7, r3, r4
1 0009 712A  // sw   r7, 2(r1)
1 000A 8431  // sgt  r8, r4, r3
1 000B 813A  // sw   r8, 3(r1)
1 000C 9333  // seq  r9, r3, r3
1 000D 914A  // sw   r9, 4(r1)
1 000E A343  // seq  r10, r3, r4
1 000F A15A  // sw   r10, 5(r1)
1 0010 B3D8  // addi r11, r3, -3
1 0011 B16A  // sw   r11, 6(r1)
1 0012 CAB5  // lui  r12, 0xAB
1 0013 C17A  // sw   r12, 7(r1)
1 0014 CCDF  // lli  r12, 0xCD
1 0015 148F  // lli  r1, 0x48
1 0016 C10A  // sw   r12, 0(r1)
1 0017 D229  // lw   r13, 2(r2)
1 0018 D2FA  // sw   r13, -1(r2)
1 0019 432B  // bne  r4, r3, +2     taken
1 001A 311A  // sw   r3, 1(r1)      skipped
1 001B 412A  // sw   r4, 2(r1)      skipped
1 001C 331B  // bne  r3, r3, +1     not taken
1 001D 911A  // sw   r9, 1(r1)
1 001E E026  // jal  r14, +2
1 001F 313A  // sw   r3, 3(r1)      skipped
1 0020 314A  // sw   r3, 4(r1)      skipped
1 0021 E12A  // sw   r14, 2(r1)
1 0022 F28F  // lli  r15, 0x28
1 0023 DF04  // jalr r13, r15
1 0024 315A  // sw   r3, 5(r1)      skipped
1 0025 416A  // sw   r4, 6(r1)      skipped
1 0028 5347  // illegal opcode 7
1 0029 534C  // illegal opcode 12
1 002A D13A  // sw   r13, 3(r1)
1 002B 6038  // addi r6, r0, 3
1 002C 66F8  // addi r6, r6, -1
1 002D 614A  // sw   r6, 4(r1)
1 002E 60DB  // bne  r6, r0, -3     loops back twice
1 002F 0FF6  // jal  r0, -1         halt
// data words
1 0080 1234
1 0081 0FF0
1 0082 BEEF
// expected stores
2 0040 2224  // add
2 0041 0244  // sub
2 0042 0001  // sgt true
2 0043 0000  // sgt false
2 0044 0001  // seq true
2 0045 0000  // seq false
2 0046 1231  // addi
2 0047 AB00  // lui
2 0048 ABCD  // lli
2 007F BEEF  // lw then sw
2 0049 0001  // after untaken bne
2 004A 001F  // jal link
2 004B 0024  // jalr link
2 004C 0002  // loop pass 1
2 004C 0001  // loop pass 2
2 004C 0000  // loop pass 3
